//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps
TOP       = lc3CpuTb
FILELIST  = sim.f
LOG       = sim.log
PASS      = TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit
(
	input  logic            Clk,
	input  logic            rstN,
	input  logic            run,
	input  logic            cont,
	input  isaPkg::opcodeE  opcode,
	input  logic            ben,
	output logic            ldMar,
	output logic            ldMdr,
	output logic            ldIr,
	output logic            ldBen,
	output logic            ldCc,
	output logic            ldReg,
	output logic            ldPc,
	output logic            memOe,
	output logic            memWe,
	output logic            paused,
	output logic            addr1UsePc,
	output logic            mdrFromMem,
	output ctrlPkg::busSrcE busSrc,
	output ctrlPkg::pcSrcE  pcSrc,
	output isaPkg::aluFuncE aluFunc
);
	import isaPkg::*;
	import ctrlPkg::*;

	ctrlStateE state, nextState;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			state <= Idle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			Idle:
			begin
				if (run)
					nextState = Fetch1;
			end
			Fetch1:     nextState = Fetch2;
			Fetch2:     nextState = Fetch3;
			Fetch3:     nextState = Decode;
			Decode:
			begin
				case (opcode)
					opAdd, opAnd, opNot: nextState = Exec;
					opBr:    nextState = BranchTake;
					opJmp:   nextState = JumpTake;
					opLd:    nextState = LdAddr;
					opSt:    nextState = StAddr;
					opPause: nextState = Paused;
					default: nextState = Fetch1;    // Unknown opcode is skipped
				endcase
			end
			LdAddr:     nextState = LdRead;
			LdRead:     nextState = LdWrite;
			StAddr:     nextState = StData;
			StData:     nextState = StWrite;
			Paused:
			begin
				if (cont)
					nextState = Resume;
			end
			default:    nextState = Fetch1;    // Last state of every instruction
		endcase
	end

	// Strobes per state, everything low unless named
	always_comb
	begin
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr = 1'b0;
		ldBen = 1'b0;
		ldCc = 1'b0;
		ldReg = 1'b0;
		ldPc = 1'b0;
		memOe = 1'b0;
		memWe = 1'b0;
		addr1UsePc = 1'b0;
		mdrFromMem = 1'b0;
		busSrc = busPc;
		pcSrc = pcInc;
		case (state)
			Fetch1:
			begin
				ldMar = 1'b1;    // MAR <- PC
				ldPc = 1'b1;     // PC <- PC + 1
			end
			Fetch2, LdRead:
			begin
				memOe = 1'b1;
				ldMdr = 1'b1;
				mdrFromMem = 1'b1;
			end
			Fetch3:
			begin
				busSrc = busMdr;
				ldIr = 1'b1;
			end
			Decode:     ldBen = 1'b1;
			Exec:
			begin
				busSrc = busAlu;
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			BranchTake:
			begin
				addr1UsePc = 1'b1;
				pcSrc = pcAddr;
				ldPc = ben;
			end
			// Base register reaches the bus through the ALU pass path
			JumpTake:
			begin
				busSrc = busAlu;
				pcSrc = pcBus;
				ldPc = 1'b1;
			end
			LdAddr, StAddr:
			begin
				addr1UsePc = 1'b1;
				busSrc = busAddr;
				ldMar = 1'b1;
			end
			LdWrite:
			begin
				busSrc = busMdr;
				ldReg = 1'b1;
				ldCc = 1'b1;
			end
			StData:
			begin
				busSrc = busAlu;
				ldMdr = 1'b1;
			end
			StWrite:    memWe = 1'b1;
			default:    ;
		endcase
	end

	assign paused = (state == Paused);

	// JMP and ST fall to the pass path
	always_comb
	begin
		case (opcode)
			opAdd:   aluFunc = aluAdd;
			opAnd:   aluFunc = aluAnd;
			opNot:   aluFunc = aluNot;
			default: aluFunc = aluPassA;
		endcase
	end

	// The SRAM is either read or written in a cycle
	assert property (@(posedge Clk) disable iff (!rstN) !(memOe && memWe));

	assert property (@(posedge Clk) disable iff (!rstN)
		(state == Idle || state == Paused) |-> !ldPc);

endmodule

//--- logic/ctrlPkg.sv
package ctrlPkg;

	// Sequencer states
	typedef enum logic [3:0]
	{
		Idle, Fetch1, Fetch2, Fetch3,
		Decode, Exec, BranchTake, JumpTake,
		LdAddr, LdRead, LdWrite, StAddr,
		StData, StWrite, Paused, Resume
	} ctrlStateE;

	typedef enum logic [1:0]
	{
		busPc   = 2'b00,
		busMdr  = 2'b01,
		busAlu  = 2'b10,
		busAddr = 2'b11    // Address adder result
	} busSrcE;

	// Next PC source
	typedef enum logic [1:0]
	{
		pcInc  = 2'b00,
		pcAddr = 2'b01,
		pcBus  = 2'b10
	} pcSrcE;

endpackage

//--- logic/dataPath.sv
`timescale 1ns/1ps
`include "lc3Defs.svh"

module dataPath
(
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   ldMar,
	input  logic                   ldMdr,
	input  logic                   ldIr,
	input  logic                   ldBen,
	input  logic                   ldCc,
	input  logic                   ldReg,
	input  logic                   ldPc,
	input  logic                   addr1UsePc,
	input  logic                   mdrFromMem,
	input  ctrlPkg::busSrcE        busSrc,
	input  ctrlPkg::pcSrcE         pcSrc,
	input  isaPkg::aluFuncE        aluFunc,
	input  logic [`WORD_WIDTH-1:0] memRdData,
	output isaPkg::opcodeE         opcode,
	output logic                   ben,
	output logic [`WORD_WIDTH-1:0] pc,
	output logic [`WORD_WIDTH-1:0] ir,
	output logic [`WORD_WIDTH-1:0] mar,
	output logic [`WORD_WIDTH-1:0] mdr
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic [`WORD_WIDTH-1:0] bus, pcNext, aluOut, addrOut, sr1Data, sr2Data;
	logic [2:0] sr1Sel;

	assign opcode = opcodeE'(ir[15:12]);

	// Internal bus, one source per cycle
	always_comb
	begin
		case (busSrc)
			busPc:   bus = pc;
			busMdr:  bus = mdr;
			busAlu:  bus = aluOut;
			default: bus = addrOut;
		endcase
	end

	always_comb
	begin
		case (pcSrc)
			pcAddr:  pcNext = addrOut;    // Taken branch
			pcBus:   pcNext = bus;        // JMP
			default: pcNext = pc + 1'b1;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= `RESET_PC;
			ir <= '0;
			mar <= '0;
			mdr <= '0;
		end
		else
		begin
			if (ldPc)
				pc <= pcNext;
			if (ldIr)
				ir <= bus;
			if (ldMar)
				mar <= bus;
			if (ldMdr)
				mdr <= mdrFromMem ? memRdData : bus;
		end
	end

	// ST reads its source from the DR field
	assign sr1Sel = (opcode == opSt) ? ir[11:9] : ir[8:6];

	regFile regFile0
	(
		.Clk, .rstN, .ldReg,
		.dr(ir[11:9]), .sr1(sr1Sel), .sr2(ir[2:0]),
		.wrData(bus), .sr1Data, .sr2Data
	);

	executeUnit execUnit0
	(
		.Clk, .rstN, .ldCc, .ldBen, .addr1UsePc, .aluFunc,
		.ir, .sr1Data, .sr2Data, .pc, .bus,
		.aluOut, .addrOut, .ben
	);

endmodule

//--- logic/executeUnit.sv
`timescale 1ns/1ps
`include "lc3Defs.svh"

module executeUnit
(
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   ldCc,
	input  logic                   ldBen,
	input  logic                   addr1UsePc,
	input  isaPkg::aluFuncE        aluFunc,
	input  logic [`WORD_WIDTH-1:0] ir,
	input  logic [`WORD_WIDTH-1:0] sr1Data,
	input  logic [`WORD_WIDTH-1:0] sr2Data,
	input  logic [`WORD_WIDTH-1:0] pc,
	input  logic [`WORD_WIDTH-1:0] bus,
	output logic [`WORD_WIDTH-1:0] aluOut,
	output logic [`WORD_WIDTH-1:0] addrOut,
	output logic                   ben
);
	import isaPkg::*;

	logic [`WORD_WIDTH-1:0] imm5, off9, aluB, addr1, addr2;
	logic [2:0] nzp;
	logic ccValid;    // Set by the first CC load

	assign imm5 = {{(`WORD_WIDTH-5){ir[4]}}, ir[4:0]};
	assign off9 = {{(`WORD_WIDTH-9){ir[8]}}, ir[8:0]};
	assign aluB = ir[5] ? imm5 : sr2Data;    // Immediate form when IR[5] is set

	always_comb
	begin
		case (aluFunc)
			aluAdd:  aluOut = sr1Data + aluB;
			aluAnd:  aluOut = sr1Data & aluB;
			aluNot:  aluOut = ~sr1Data;
			default: aluOut = sr1Data;
		endcase
	end

	// JMP adds nothing to its base register
	assign addr1 = addr1UsePc ? pc : sr1Data;
	assign addr2 = (opcodeE'(ir[15:12]) == opJmp) ? '0 : off9;
	assign addrOut = addr1 + addr2;

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			nzp <= 3'b000;
			ccValid <= 1'b0;
		end
		else if (ldCc)
		begin
			nzp <= {bus[`WORD_WIDTH-1], bus == '0, !bus[`WORD_WIDTH-1] && bus != '0};
			ccValid <= 1'b1;
		end
	end

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
			ben <= 1'b0;
		else if (ldBen)
			ben <= |(ir[11:9] & nzp);    // BR condition bits against NZP
	end

	assert property (@(posedge Clk) disable iff (!rstN) ccValid |-> $onehot(nzp));

endmodule

//--- logic/isaPkg.sv
package isaPkg;

	// IR[15:12], standard LC-3 codes
	typedef enum logic [3:0]
	{
		opBr    = 4'b0000,
		opAdd   = 4'b0001,
		opLd    = 4'b0010,
		opSt    = 4'b0011,
		opAnd   = 4'b0101,
		opNot   = 4'b1001,
		opJmp   = 4'b1100,
		opPause = 4'b1111    // Sits on the TRAP code
	} opcodeE;

	typedef enum logic [1:0]
	{
		aluAdd   = 2'b00,
		aluAnd   = 2'b01,
		aluNot   = 2'b10,
		aluPassA = 2'b11     // SR1 straight through
	} aluFuncE;

endpackage

//--- logic/lc3Cpu.sv
`timescale 1ns/1ps
`include "lc3Defs.svh"

module lc3Cpu
(
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   run,
	input  logic                   cont,
	input  logic [`WORD_WIDTH-1:0] memRdData,
	output logic [`WORD_WIDTH-1:0] memAddr,
	output logic [`WORD_WIDTH-1:0] memWrData,
	output logic                   memOe,
	output logic                   memWe,
	output logic [`WORD_WIDTH-1:0] pc,
	output logic [`WORD_WIDTH-1:0] ir,
	output logic                   paused
);
	import isaPkg::*;
	import ctrlPkg::*;

	logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc;
	logic addr1UsePc, mdrFromMem, ben;
	busSrcE busSrc;
	pcSrcE pcSrc;
	aluFuncE aluFunc;
	opcodeE opcode;

	controlUnit ctrl0
	(
		.Clk, .rstN, .run, .cont, .opcode, .ben,
		.ldMar, .ldMdr, .ldIr, .ldBen, .ldCc, .ldReg, .ldPc,
		.memOe, .memWe, .paused, .addr1UsePc, .mdrFromMem,
		.busSrc, .pcSrc, .aluFunc
	);

	// SRAM address and write data come straight from MAR and MDR
	dataPath dataPath0
	(
		.Clk, .rstN,
		.ldMar, .ldMdr, .ldIr, .ldBen, .ldCc, .ldReg, .ldPc,
		.addr1UsePc, .mdrFromMem, .busSrc, .pcSrc, .aluFunc, .memRdData,
		.opcode, .ben, .pc, .ir, .mar(memAddr), .mdr(memWrData)
	);

endmodule

//--- logic/lc3Defs.svh
`ifndef LC3_DEFS_SVH
`define LC3_DEFS_SVH

// Data and address width
`define WORD_WIDTH 16

`define REG_COUNT 8    // R0 to R7

// Where the first fetch after Run lands
`define RESET_PC 16'h3000

`endif

//--- logic/regFile.sv
`timescale 1ns/1ps
`include "lc3Defs.svh"

module regFile
(
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   ldReg,
	input  logic [2:0]             dr,
	input  logic [2:0]             sr1,
	input  logic [2:0]             sr2,
	input  logic [`WORD_WIDTH-1:0] wrData,
	output logic [`WORD_WIDTH-1:0] sr1Data,
	output logic [`WORD_WIDTH-1:0] sr2Data
);

	logic [`WORD_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge Clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end
		else if (ldReg)
		begin
			regs[dr] <= wrData;    // Write takes the bus value
		end
	end

	// Reads are combinational
	assign sr1Data = regs[sr1];
	assign sr2Data = regs[sr2];

endmodule

//--- sim.f
+incdir+logic
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/controlUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/dataPath.sv
logic/lc3Cpu.sv
tests/sramModel.sv
tests/lc3CpuTb.sv

//--- tests/lc3CpuTb.sv
`timescale 1ns/1ps
`include "lc3Defs.svh"

module lc3CpuTb;

	localparam logic [15:0] loadWord0 = 16'h7A35;
	localparam logic [15:0] loadWord1 = 16'h9C6E;
	localparam logic [15:0] jumpTarget = `RESET_PC + 16'h10;
	localparam logic [15:0] storeBase = `RESET_PC + 16'h30;
	// About 140 cycles with the longest pause, so 400 leaves ample margin
	localparam int cycleLimit = 400;

	logic Clk, rstN, run, cont;
	logic [`WORD_WIDTH-1:0] memRdData, memAddr, memWrData, pc, ir;
	logic memOe, memWe, paused;

	logic [15:0] expReadAddr [32];
	logic expReadFetch [32];    // Instruction fetch rather than LD data
	logic [15:0] expStoreAddr [8];
	logic [15:0] expStoreData [8];
	logic [4:0] readTotal, rdIdx;
	logic [2:0] storeTotal, wrIdx;
	int cycleCnt, lastFetch, expGap;    // expGap of 0 skips the spacing check
	logic [15:0] prevPc, prevIr;
	logic prevPaused, started;
	integer seed;
	int pauseDelay;

	lc3Cpu dut0
	(
		.Clk, .rstN, .run, .cont, .memRdData, .memAddr, .memWrData,
		.memOe, .memWe, .pc, .ir, .paused
	);

	sramModel #(.loadWord0(loadWord0), .loadWord1(loadWord1), .jumpTarget(jumpTarget)) sram0
	(
		.Clk, .addr(memAddr), .wrData(memWrData), .we(memWe), .rdData(memRdData)
	);

	task automatic stopOnError();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic noteRead(input logic [15:0] addr, input logic isFetch);
		expReadAddr[readTotal] = addr;
		expReadFetch[readTotal] = isFetch;
		readTotal = readTotal + 5'd1;
	endtask

	task automatic expectStore(input logic [15:0] addr, input logic [15:0] data);
		expStoreAddr[storeTotal] = addr;
		expStoreData[storeTotal] = data;
		storeTotal = storeTotal + 3'd1;
	endtask

	initial
	begin
		Clk = 1'b0;
		forever #10 Clk = ~Clk;
	end

	// Read and write progress, fetch timing and the last cycle's pc and ir
	always @(posedge Clk)
	begin
		cycleCnt <= cycleCnt + 1;
		prevPc <= pc;
		prevIr <= ir;
		prevPaused <= paused;
		if (memOe)
		begin
			rdIdx <= rdIdx + 5'd1;
			if (expReadFetch[rdIdx])
			begin
				lastFetch <= cycleCnt;
				case (memRdData[15:12])
					4'b0010, 4'b0011: expGap <= 7;    // LD, ST
					4'b1111:          expGap <= 0;    // PAUSE waits on cont
					default:          expGap <= 5;
				endcase
			end
		end
		if (memWe)
			wrIdx <= wrIdx + 3'd1;
	end

	always @(posedge Clk)
	begin
		if (cycleCnt >= cycleLimit)
		begin
			$display("Timeout: program did not reach its self-loop in %0d cycles", cycleLimit);
			stopOnError();
		end
	end

	assert property (@(posedge Clk) disable iff (!rstN) !started |-> pc == `RESET_PC)
	else
	begin
		$display("FAILED %0t: pc expected %h, got %h before Run", $time, `RESET_PC,
			$sampled(pc));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN)
		!started |-> !memOe && !memWe && !paused)
	else
	begin
		$display("FAILED %0t: {memOe,memWe,paused} expected 000, got %b%b%b", $time,
			$sampled(memOe), $sampled(memWe), $sampled(paused));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN) memWe |-> wrIdx < storeTotal)
	else
	begin
		$display("Unexpected SRAM write beyond the program's stores at %0t", $time);
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN)
		memWe |-> memAddr == expStoreAddr[wrIdx])
	else
	begin
		$display("FAILED %0t: memAddr expected %h, got %h", $time,
			expStoreAddr[$sampled(wrIdx)], $sampled(memAddr));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN)
		memWe |-> memWrData == expStoreData[wrIdx])
	else
	begin
		$display("FAILED %0t: memWrData expected %h, got %h", $time,
			expStoreData[$sampled(wrIdx)], $sampled(memWrData));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN) memOe |-> rdIdx < readTotal)
	else
	begin
		$display("Unexpected SRAM read beyond the predicted program flow at %0t", $time);
		stopOnError();
	end

	// Fetch and LD data addresses follow the predicted control flow
	assert property (@(posedge Clk) disable iff (!rstN)
		memOe |-> memAddr == expReadAddr[rdIdx])
	else
	begin
		$display("FAILED %0t: memAddr expected %h, got %h", $time,
			expReadAddr[$sampled(rdIdx)], $sampled(memAddr));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN)
		memOe && expReadFetch[rdIdx] && expGap != 0 |-> cycleCnt - lastFetch == expGap)
	else
	begin
		$display("FAILED %0t: cycles since last fetch expected %0d, got %0d", $time,
			$sampled(expGap), $sampled(cycleCnt) - $sampled(lastFetch));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN) paused |-> !memOe)
	else
	begin
		$display("FAILED %0t: memOe expected 0, got 1 while paused", $time);
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN) paused && prevPaused |-> pc == prevPc)
	else
	begin
		$display("FAILED %0t: pc expected %h, got %h while paused", $time,
			$sampled(prevPc), $sampled(pc));
		stopOnError();
	end

	assert property (@(posedge Clk) disable iff (!rstN) paused && prevPaused |-> ir == prevIr)
	else
	begin
		$display("FAILED %0t: ir expected %h, got %h while paused", $time,
			$sampled(prevIr), $sampled(ir));
		stopOnError();
	end

	// Resume and Fetch1 sit between the cont cycle and the fetch read
	assert property (@(posedge Clk) disable iff (!rstN) paused && cont |-> ##3 memOe)
	else
	begin
		$display("Fetch did not resume after the cont strobe, checked at %0t", $time);
		stopOnError();
	end

	initial
	begin
		seed = 32'hcca946c1;
		rstN = 1'b0;
		run = 1'b0;
		cont = 1'b0;
		started = 1'b0;
		cycleCnt = 0;
		lastFetch = 0;
		expGap = 0;
		rdIdx = '0;
		wrIdx = '0;
		prevPc = '0;
		prevIr = '0;
		prevPaused = 1'b0;
		readTotal = '0;
		storeTotal = '0;

		noteRead(`RESET_PC, 1'b1);
		noteRead(`RESET_PC + 16'h20, 1'b0);    // Word 0
		noteRead(`RESET_PC + 16'h01, 1'b1);
		noteRead(`RESET_PC + 16'h21, 1'b0);    // Word 1
		noteRead(`RESET_PC + 16'h02, 1'b1);
		noteRead(`RESET_PC + 16'h22, 1'b0);    // JMP target pointer
		for (int i = 3; i <= 12; i++)
			noteRead(`RESET_PC + 16'(i), 1'b1);    // ALU ops, stores, BRn falls through
		noteRead(`RESET_PC + 16'h0E, 1'b1);    // BRp taken past base+0x0D
		noteRead(jumpTarget, 1'b1);            // JMP lands on PAUSE
		noteRead(jumpTarget + 16'h01, 1'b1);
		noteRead(jumpTarget + 16'h01, 1'b1);   // Self-loop branches onto itself

		expectStore(storeBase, loadWord0 + loadWord1);
		expectStore(storeBase + 16'h01, loadWord0 + 16'hFFFD);    // imm5 -3 sign extended
		expectStore(storeBase + 16'h02, loadWord0 & loadWord1);
		expectStore(storeBase + 16'h03, ~loadWord1);

		repeat (8) @(posedge Clk);
		rstN <= 1'b1;
		repeat (5) @(posedge Clk);    // Idle cycles for the pre-Run checks
		run <= 1'b1;
		started <= 1'b1;
		@(posedge Clk);
		run <= 1'b0;

		wait (paused);
		pauseDelay = 3 + ($unsigned($random(seed)) % 18);
		repeat (pauseDelay) @(posedge Clk);
		cont <= 1'b1;
		@(posedge Clk);
		cont <= 1'b0;

		wait (rdIdx == readTotal);
		@(posedge Clk);
		if (wrIdx == storeTotal)
		begin
			$display("TEST OK");
			$finish;
		end
		else
		begin
			$display("FAILED %0t: store count expected %0d, got %0d", $time, storeTotal, wrIdx);
			stopOnError();
		end
	end

endmodule

//--- tests/sramModel.sv
`timescale 1ns/1ps
`include "lc3Defs.svh"

// Asynchronous SRAM with the test program placed at RESET_PC
module sramModel
#(
	parameter logic [`WORD_WIDTH-1:0] loadWord0 = 16'h0000,
	parameter logic [`WORD_WIDTH-1:0] loadWord1 = 16'h0000,
	parameter logic [`WORD_WIDTH-1:0] jumpTarget = `RESET_PC
)
(
	input  logic                   Clk,
	input  logic [`WORD_WIDTH-1:0] addr,
	input  logic [`WORD_WIDTH-1:0] wrData,
	input  logic                   we,
	output logic [`WORD_WIDTH-1:0] rdData
);

	localparam logic [`WORD_WIDTH-1:0] base = `RESET_PC;

	logic [`WORD_WIDTH-1:0] mem [2**`WORD_WIDTH];

	initial
	begin
		for (int a = 0; a < 2**`WORD_WIDTH; a++)
			mem[a[15:0]] <= a[15:0] ^ 16'hA5C3;    // Filler differs per address
		mem[base + 16'h00] <= 16'h221F;    // LD  R1, word 0
		mem[base + 16'h01] <= 16'h241F;    // LD  R2, word 1
		mem[base + 16'h02] <= 16'h2E1F;    // LD  R7, jump target
		mem[base + 16'h03] <= 16'h1642;    // ADD R3, R1, R2
		mem[base + 16'h04] <= 16'h187D;    // ADD R4, R1, #-3
		mem[base + 16'h05] <= 16'h5A42;    // AND R5, R1, R2
		mem[base + 16'h06] <= 16'h9CBF;    // NOT R6, R2
		mem[base + 16'h07] <= 16'h3628;    // ST  R3 to base+0x30
		mem[base + 16'h08] <= 16'h3828;    // ST  R4 to base+0x31
		mem[base + 16'h09] <= 16'h3A28;    // ST  R5 to base+0x32
		mem[base + 16'h0A] <= 16'h3C28;    // ST  R6 to base+0x33
		mem[base + 16'h0B] <= 16'h0801;    // BRn +1, CC is P here so not taken
		mem[base + 16'h0C] <= 16'h0201;    // BRp +1, skips base+0x0D
		mem[base + 16'h0E] <= 16'hC1C0;    // JMP R7
		mem[jumpTarget] <= 16'hF000;                 // PAUSE
		mem[jumpTarget + 16'h01] <= 16'h0FFF;        // BRnzp -1, self-loop
		mem[base + 16'h20] <= loadWord0;
		mem[base + 16'h21] <= loadWord1;
		mem[base + 16'h22] <= jumpTarget;
	end

	always @(posedge Clk)
	begin
		if (we)
			mem[addr] <= wrData;
	end

	assign rdData = mem[addr];    // No clock on the read side

endmodule
